// File: sim.f
+incdir+include
hw/vmem_pkg.sv
hw/map_ram.sv
hw/vmem_lookup_ctrl.sv
hw/vmem_decode.sv
hw/vmem_map.sv
sim/vmem_map_sva.sv
sim/vmem_map_tb.sv

// File: sim/vmem_map_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "vmem_cfg.svh"

module vmem_map_tb
   import vmem_pkg::*;
();

   localparam int TIMEOUT = 20;

   logic                                 clk;
   logic                                 reset;
   logic [`VMEM_PAGE_MSB:`VMEM_PAGE_LSB] mapi;
   logic [`VMEM_VMA_W-1:0]               vma;
   logic                                 map_rd;
   logic                                 map_wr_req;
   logic                                 vm0wp;
   logic                                 vm1wp;
   logic                                 result_valid;
   l2_entry_t                            vmo;
   pma_t                                 pma;
   logic                                 access_fault;
   logic                                 write_fault;

   // Reference maps
   vmap_t     ref_l1 [0:`VMEM_L1_DEPTH-1];
   l2_entry_t ref_l2 [0:`VMEM_L2_DEPTH-1];

   // Pending lookups for the next burst
   logic [`VMEM_PAGE_MSB:`VMEM_PAGE_LSB] q_page [$];
   logic [`VMEM_OFS_W-1:0]               q_ofs  [$];
   logic                                 q_wr   [$];

   int err_value;
   int err_other;

   initial clk = 1'b0;
   always #4 clk = ~clk;

   vmem_map dut (
      .clk          (clk),
      .reset        (reset),
      .mapi         (mapi),
      .vma          (vma),
      .map_rd       (map_rd),
      .map_wr_req   (map_wr_req),
      .vm0wp        (vm0wp),
      .vm1wp        (vm1wp),
      .result_valid (result_valid),
      .vmo          (vmo),
      .pma          (pma),
      .access_fault (access_fault),
      .write_fault  (write_fault)
   );

   ////////////////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////////////////

   task automatic check_entry(input string name, input l2_entry_t exp, input l2_entry_t act);
      if (act !== exp) begin
         err_value++;
         $display("ERR %s vmo: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_pma(input string name, input pma_t exp, input pma_t act);
      if (act !== exp) begin
         err_value++;
         $display("ERR %s pma: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input bit exp, input logic act);
      if (act !== exp) begin
         err_value++;
         $display("ERR %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Drivers
   ////////////////////////////////////////////////////////////////////////

   // Inputs change 1 ns after the edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic idle(input int n);
      map_rd = 1'b0;
      vm0wp  = 1'b0;
      vm1wp  = 1'b0;
      repeat (n) next_cycle();
   endtask

   // Block number into level 1 at the region of a page
   task automatic write_l1(input l1_addr_t a, input vmap_t blk);
      mapi  = {a, {`VMEM_SEL_W{1'b0}}};
      vma   = {27'($urandom), blk};
      vm0wp = 1'b1;
      next_cycle();
      vm0wp = 1'b0;
      ref_l1[a] = blk;
   endtask

   // Lookup strobe, then the level-2 write one cycle later
   task automatic write_l2(input logic [`VMEM_PAGE_MSB:`VMEM_PAGE_LSB] page,
                           input l2_entry_t e);
      l2_addr_t dst;
      dst = {ref_l1[page[`VMEM_PAGE_MSB:`VMEM_L1_LSB]], page[`VMEM_L1_LSB-1:`VMEM_PAGE_LSB]};
      mapi       = page;
      map_wr_req = 1'b0;
      map_rd     = 1'b1;
      next_cycle();
      map_rd = 1'b0;
      vma    = {8'($urandom), e};
      vm1wp  = 1'b1;
      next_cycle();
      vm1wp = 1'b0;
      ref_l2[dst] = e;
   endtask

   task automatic add_lookup(input logic [`VMEM_PAGE_MSB:`VMEM_PAGE_LSB] page,
                             input logic [`VMEM_OFS_W-1:0] ofs, input logic wr);
      q_page.push_back(page);
      q_ofs.push_back(ofs);
      q_wr.push_back(wr);
   endtask

   // Back-to-back strobes, results checked in order as they land
   task automatic run_lookups(input string name);
      int        n;
      int        sent;
      int        got;
      int        cyc;
      string     tag;
      vmap_t     blk;
      l2_entry_t e;
      logic [`VMEM_PAGE_MSB:`VMEM_PAGE_LSB] page;
      n    = q_page.size();
      sent = 0;
      got  = 0;
      // Let stale results from map writes drain
      idle(4);
      for (cyc = 0; cyc < n + 3 + TIMEOUT && got < n; cyc++) begin
         if (sent < n) begin
            mapi       = q_page[sent];
            vma        = {24'($urandom), q_ofs[sent]};
            map_wr_req = q_wr[sent];
            map_rd     = 1'b1;
            sent++;
         end else begin
            map_rd = 1'b0;
         end
         next_cycle();
         if (result_valid === 1'b1) begin
            tag = $sformatf("%s #%0d", name, got);
            // Lookup k sampled at edge k of this loop
            // Result seen after edge cyc is sampled at edge cyc+1
            if (cyc + 1 - got != 3) begin
               err_other++;
               $display("%s arrived %0d cycles after its strobe instead of 3",
                        tag, cyc + 1 - got);
            end
            page = q_page[got];
            blk  = ref_l1[page[`VMEM_PAGE_MSB:`VMEM_L1_LSB]];
            e    = ref_l2[{blk, page[`VMEM_L1_LSB-1:`VMEM_PAGE_LSB]}];
            check_entry(tag, e, vmo);
            check_pma(tag, {e.ppn, q_ofs[got]}, pma);
            check_flag({tag, " access_fault"}, !e.access, access_fault);
            check_flag({tag, " write_fault"}, e.access && q_wr[got] && !e.write_ok,
                       write_fault);
            got++;
         end
      end
      map_rd = 1'b0;
      if (got < n) begin
         err_other++;
         $display("%s timed out with %0d of %0d results", name, got, n);
      end
      q_page.delete();
      q_ofs.delete();
      q_wr.delete();
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////

   task automatic test_reset();
      repeat (5) begin
         check_flag("reset result_valid", 1'b0, result_valid);
         check_entry("reset", '0, vmo);
         check_pma("reset", '0, pma);
         next_cycle();
      end
   endtask

   task automatic test_write_lookup();
      write_l1(11'h091, 5'd7);
      write_l2({11'h091, 5'd12}, {1'b1, 1'b1, 2'b10, 6'h15, 14'h2abc});
      add_lookup({11'h091, 5'd12}, 8'h5a, 1'b0);
      add_lookup({11'h091, 5'd12}, 8'hc3, 1'b1);
      run_lookups("write_lookup");
   endtask

   // Unmapped, read-only and writable pages, read and write intent each
   task automatic test_faults();
      write_l1(11'h123, 5'd9);
      write_l2({11'h123, 5'd0}, {1'b0, 1'b1, 2'b01, 6'h00, 14'h0111});
      write_l2({11'h123, 5'd1}, {1'b1, 1'b0, 2'b00, 6'h3f, 14'h0222});
      write_l2({11'h123, 5'd2}, {1'b1, 1'b1, 2'b11, 6'h2a, 14'h0333});
      for (int i = 0; i < 6; i++) begin
         add_lookup({11'h123, 5'(i / 2)}, 8'(i * 17), 1'(i % 2));
      end
      run_lookups("faults");
   endtask

   // Eight pages, eight blocks, eight strobes in a row
   task automatic test_pipeline();
      logic [`VMEM_PAGE_MSB:`VMEM_PAGE_LSB] page;
      for (int i = 0; i < 8; i++) begin
         page = {11'(11'h040 + i * 37), 5'(i * 3)};
         write_l1(page[`VMEM_PAGE_MSB:`VMEM_L1_LSB], 5'(i + 16));
         write_l2(page, 24'($urandom));
         add_lookup(page, 8'($urandom), 1'($urandom));
      end
      run_lookups("pipeline");
   endtask

   task automatic test_random();
      logic [`VMEM_PAGE_MSB:`VMEM_PAGE_LSB] pages [0:31];
      // Whole level 1, so every page resolves to a known block
      for (int a = 0; a < `VMEM_L1_DEPTH; a++) begin
         write_l1(l1_addr_t'(a), vmap_t'($urandom));
      end
      for (int k = 0; k < 32; k++) begin
         pages[k] = 16'($urandom);
         write_l2(pages[k], 24'($urandom));
      end
      for (int j = 0; j < 64; j++) begin
         add_lookup(pages[$urandom % 32], 8'($urandom), 1'($urandom));
      end
      run_lookups("random");
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Sequence
   ////////////////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(32'h0dbb_9a7f));
      err_value  = 0;
      err_other  = 0;
      reset      = 1'b1;
      mapi       = '0;
      vma        = '0;
      map_rd     = 1'b0;
      map_wr_req = 1'b0;
      vm0wp      = 1'b0;
      vm1wp      = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      test_reset();
      test_write_lookup();
      test_faults();
      test_pipeline();
      test_random();
      idle(4);
      $display("Errors: %0d value, %0d other", err_value, err_other);
      if (err_value == 0 && err_other == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/vmem_map_sva.sv
`timescale 1ns/10ps
`default_nettype none

`include "vmem_cfg.svh"

//////////////////////////////////////////////////////////////////////
// Pipeline timing and strobe exclusion checks
//////////////////////////////////////////////////////////////////////

module vmem_map_sva
   import vmem_pkg::*;
(
   input logic clk,
   input logic reset,
   input logic map_rd,
   input logic vm0wp,
   input logic result_valid,
   input logic access_fault,
   input logic write_fault
);

   // Every strobe answered three cycles on
   a_latency: assert property (@(posedge clk) disable iff (reset)
      map_rd |-> ##3 result_valid)
      else $error("lookup strobe without a result three cycles later");

   // No result without a strobe three cycles back
   a_origin: assert property (@(posedge clk) disable iff (reset)
      result_valid |-> $past(map_rd, 3))
      else $error("result_valid without a matching lookup strobe");

   // Valid register cleared by every reset cycle
   a_reset: assert property (@(posedge clk)
      reset |=> !result_valid)
      else $error("result_valid high during reset");

   // Write fault masked on an unmapped page
   a_faults: assert property (@(posedge clk) disable iff (reset)
      !(access_fault && write_fault))
      else $error("access_fault and write_fault high together");

   // Level-1 read and write share one address port
   a_l1_excl: assert property (@(posedge clk) disable iff (reset)
      !(vm0wp && map_rd))
      else $error("level-1 write in a lookup cycle");

endmodule

bind vmem_map vmem_map_sva u_sva (
   .clk          (clk),
   .reset        (reset),
   .map_rd       (map_rd),
   .vm0wp        (vm0wp),
   .result_valid (result_valid),
   .access_fault (access_fault),
   .write_fault  (write_fault)
);

`default_nettype wire

// File: hw/vmem_map.sv
`timescale 1ns/10ps
`default_nettype none

`include "vmem_cfg.svh"

//////////////////////////////////////////////////////////////////////
// Two-level virtual memory map
//////////////////////////////////////////////////////////////////////

// mapi carries page address bits 23..8
// vm0wp writes level 1 at the page of this cycle
// vm1wp writes level 2 at the address of the lookup one cycle back
// Result three cycles after map_rd
module vmem_map
   import vmem_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic [`VMEM_PAGE_MSB:`VMEM_PAGE_LSB] mapi,
   input  logic [`VMEM_VMA_W-1:0]               vma,
   input  logic                                 map_rd,
   input  logic                                 map_wr_req,
   input  logic                                 vm0wp,
   input  logic                                 vm1wp,
   output logic                                 result_valid,
   output l2_entry_t                            vmo,
   output pma_t                                 pma,
   output logic                                 access_fault,
   output logic                                 write_fault
);

   // Level-1 side
   wire l1_addr_t                l1_addr;
   wire vmap_t                   vmap;

   // Level-2 side
   wire l2_addr_t                l2_addr;
   wire                          l2_rd_en;
   wire l2_entry_t               l2_entry;

   // Stage 2 fields toward decode
   wire                          s2_valid;
   wire [`VMEM_OFS_W-1:0]        s2_offset;
   wire                          s2_wr_req;

   //////////////////////////////////////////////////////////////////////
   // Level-1 map, block numbers
   //////////////////////////////////////////////////////////////////////

   // Read on the lookup strobe, write data from low vma bits
   map_ram #(
      .entry_t (vmap_t),
      .AW      (`VMEM_L1_AW),
      .DEPTH   (`VMEM_L1_DEPTH)
   ) u_l1 (
      .clk     (clk),
      .reset   (reset),
      .addr    (l1_addr),
      .rd_en   (map_rd),
      .wr_en   (vm0wp),
      .wr_data (vmap_t'(vma[`VMEM_BLK_W-1:0])),
      .rd_data (vmap)
   );

   //////////////////////////////////////////////////////////////////////
   // Pipeline control
   //////////////////////////////////////////////////////////////////////

   vmem_lookup_ctrl u_ctrl (
      .clk        (clk),
      .reset      (reset),
      .map_rd     (map_rd),
      .map_wr_req (map_wr_req),
      .mapi       (mapi),
      .vma        (vma),
      .vmap       (vmap),
      .l1_addr    (l1_addr),
      .l2_addr    (l2_addr),
      .l2_rd_en   (l2_rd_en),
      .s2_valid   (s2_valid),
      .s2_offset  (s2_offset),
      .s2_wr_req  (s2_wr_req)
   );

   //////////////////////////////////////////////////////////////////////
   // Level-2 map, page entries
   //////////////////////////////////////////////////////////////////////

   map_ram #(
      .entry_t (l2_entry_t),
      .AW      (`VMEM_L2_AW),
      .DEPTH   (`VMEM_L2_DEPTH)
   ) u_l2 (
      .clk     (clk),
      .reset   (reset),
      .addr    (l2_addr),
      .rd_en   (l2_rd_en),
      .wr_en   (vm1wp),
      .wr_data (l2_entry_t'(vma[`VMEM_ENTRY_W-1:0])),
      .rd_data (l2_entry)
   );

   //////////////////////////////////////////////////////////////////////
   // Decode
   //////////////////////////////////////////////////////////////////////

   vmem_decode u_decode (
      .clk          (clk),
      .reset        (reset),
      .s2_valid     (s2_valid),
      .s2_offset    (s2_offset),
      .s2_wr_req    (s2_wr_req),
      .entry        (l2_entry),
      .result_valid (result_valid),
      .vmo          (vmo),
      .pma          (pma),
      .access_fault (access_fault),
      .write_fault  (write_fault)
   );

endmodule

`default_nettype wire

// File: hw/vmem_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "vmem_cfg.svh"

//////////////////////////////////////////////////////////////////////
// Level-2 entry decode
//////////////////////////////////////////////////////////////////////

// Last pipeline stage, splits the entry into address and faults
// Results hold between lookups
module vmem_decode
   import vmem_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   s2_valid,
   input  logic [`VMEM_OFS_W-1:0] s2_offset,
   input  logic                   s2_wr_req,
   input  l2_entry_t              entry,
   output logic                   result_valid,
   output l2_entry_t              vmo,
   output pma_t                   pma,
   output logic                   access_fault,
   output logic                   write_fault
);

   // Next-state values
   pma_t pma_d;
   logic access_fault_d;
   logic write_fault_d;

   //////////////////////////////////////////////////////////////////////
   // Field split
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      // Page number over word offset
      pma_d          = pma_of(entry, s2_offset);
      // Unmapped page
      access_fault_d = !entry.access;
      // Only reported on a mapped page
      write_fault_d  = write_fault_of(entry, s2_wr_req) && !access_fault_d;
   end

   //////////////////////////////////////////////////////////////////////
   // Result registers
   //////////////////////////////////////////////////////////////////////

   // Valid pulse for one cycle per lookup
   always_ff @(posedge clk) begin
      if (reset) begin
         result_valid <= 1'b0;
      end else begin
         result_valid <= s2_valid;
      end
   end

   // Zero after reset until the first lookup lands
   always_ff @(posedge clk) begin
      if (reset) begin
         vmo          <= '0;
         pma          <= '0;
         access_fault <= 1'b0;
         write_fault  <= 1'b0;
      end else if (s2_valid) begin
         vmo          <= entry;
         pma          <= pma_d;
         access_fault <= access_fault_d;
         write_fault  <= write_fault_d;
      end
   end

endmodule

`default_nettype wire

// File: hw/vmem_lookup_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "vmem_cfg.svh"

//////////////////////////////////////////////////////////////////////
// Lookup pipeline control
//////////////////////////////////////////////////////////////////////

// Stage 0: map_rd strobe, level-1 read addressed straight from mapi
// Stage 1: block number out of level 1, level-2 address formed here
// Stage 2: level-2 entry out, fields handed to decode
module vmem_lookup_ctrl
   import vmem_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 map_rd,
   input  logic                                 map_wr_req,
   input  logic [`VMEM_PAGE_MSB:`VMEM_PAGE_LSB] mapi,
   input  logic [`VMEM_VMA_W-1:0]               vma,
   input  vmap_t                                vmap,
   output l1_addr_t                             l1_addr,
   output l2_addr_t                             l2_addr,
   output logic                                 l2_rd_en,
   output logic                                 s2_valid,
   output logic [`VMEM_OFS_W-1:0]               s2_offset,
   output logic                                 s2_wr_req
);

   // Stage 1 state
   logic                   s1_valid;
   logic [`VMEM_SEL_W-1:0] s1_sel;
   logic [`VMEM_OFS_W-1:0] s1_offset;
   logic                   s1_wr_req;

   //////////////////////////////////////////////////////////////////////
   // Level-1 address
   //////////////////////////////////////////////////////////////////////

   // Upper page bits, also the level-1 write address
   assign l1_addr = l1_addr_of(mapi);

   //////////////////////////////////////////////////////////////////////
   // Valid shift
   //////////////////////////////////////////////////////////////////////

   // One bit per stage, no stall
   always_ff @(posedge clk) begin
      if (reset) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else begin
         s1_valid <= map_rd;
         s2_valid <= s1_valid;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Carried request fields
   //////////////////////////////////////////////////////////////////////

   // Captured at the strobe, so each result keeps its own offset
   always_ff @(posedge clk) begin
      if (map_rd) begin
         s1_sel    <= l2_sel_of(mapi);
         s1_offset <= vma[`VMEM_OFS_W-1:0];
         s1_wr_req <= map_wr_req;
      end
   end

   // Follows the level-2 read by one stage
   always_ff @(posedge clk) begin
      if (s1_valid) begin
         s2_offset <= s1_offset;
         s2_wr_req <= s1_wr_req;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Level-2 address
   //////////////////////////////////////////////////////////////////////

   // Block number fresh from level 1 with the carried page select
   // Also the target of a level-2 write one cycle after the strobe
   assign l2_addr  = l2_addr_of(vmap, s1_sel);
   assign l2_rd_en = s1_valid;

endmodule

`default_nettype wire

// File: hw/map_ram.sv
`timescale 1ns/10ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Single-port map RAM
//////////////////////////////////////////////////////////////////////

// One address shared by read and write
// Write wins, read output holds during a write
module map_ram #(
   parameter type entry_t = logic [7:0],
   parameter int  AW      = 8,
   parameter int  DEPTH   = 256
) (
   input  logic          clk,
   input  logic          reset,
   input  logic [AW-1:0] addr,
   input  logic          rd_en,
   input  logic          wr_en,
   input  entry_t        wr_data,
   output entry_t        rd_data
);

   //////////////////////////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////////////////////////

   // Contents survive reset
   entry_t mem [0:DEPTH-1];

   //////////////////////////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////////////////////////

   // Strobe edge writes the entry
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[addr] <= wr_data;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Registered read
   //////////////////////////////////////////////////////////////////////

   // Output register cleared on reset
   // Reads only in a cycle with no write
   // A read slot hit by a write keeps the old word
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_data <= '0;
      end else if (rd_en && !wr_en) begin
         rd_data <= mem[addr];
      end
   end

endmodule

`default_nettype wire

// File: hw/vmem_pkg.sv
`default_nettype none

`include "vmem_cfg.svh"

package vmem_pkg;

   //////////////////////////////////////////////////////////////////////
   // Map entry types
   //////////////////////////////////////////////////////////////////////

   // Level-1 entry, block number only
   typedef logic [`VMEM_BLK_W-1:0] vmap_t;

   // Level-2 entry, permission bits on top, page number at the bottom
   typedef struct packed {
      logic                                    access;
      logic                                    write_ok;
      logic [1:0]                              status;
      logic [`VMEM_ENTRY_W-`VMEM_PPN_W-5:0]    spare;
      logic [`VMEM_PPN_W-1:0]                  ppn;
   } l2_entry_t;

   // Physical word address
   typedef logic [`VMEM_PMA_W-1:0] pma_t;

   // Map addresses
   typedef logic [`VMEM_L1_AW-1:0] l1_addr_t;
   typedef logic [`VMEM_L2_AW-1:0] l2_addr_t;

   //////////////////////////////////////////////////////////////////////
   // Field helpers
   //////////////////////////////////////////////////////////////////////

   // Page bits 23..13 index level 1
   function automatic l1_addr_t l1_addr_of(input logic [`VMEM_PAGE_MSB:`VMEM_PAGE_LSB] page);
      return page[`VMEM_PAGE_MSB:`VMEM_L1_LSB];
   endfunction

   // Page bits 12..8 select within a block
   function automatic logic [`VMEM_SEL_W-1:0] l2_sel_of(
      input logic [`VMEM_PAGE_MSB:`VMEM_PAGE_LSB] page);
      return page[`VMEM_L1_LSB-1:`VMEM_PAGE_LSB];
   endfunction

   // Block number in the upper half of the level-2 index
   function automatic l2_addr_t l2_addr_of(input vmap_t blk,
                                           input logic [`VMEM_SEL_W-1:0] sel);
      return {blk, sel};
   endfunction

   // Physical page on top of the word offset
   function automatic pma_t pma_of(input l2_entry_t e, input logic [`VMEM_OFS_W-1:0] ofs);
      return {e.ppn, ofs};
   endfunction

   // Write to a mapped page that forbids writes
   function automatic logic write_fault_of(input l2_entry_t e, input logic wr_req);
      return e.access && wr_req && !e.write_ok;
   endfunction

endpackage

`default_nettype wire

// File: include/vmem_cfg.svh
`ifndef VMEM_CFG_SVH
`define VMEM_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Map geometry
//////////////////////////////////////////////////////////////////////

// Level-1 map, one block number per 8 KW region
`define VMEM_L1_AW    11
`define VMEM_L1_DEPTH 2048

// Level-2 map, block number joined with page select
`define VMEM_L2_AW    10
`define VMEM_L2_DEPTH 1024

// Entry widths
`define VMEM_BLK_W    5
`define VMEM_ENTRY_W  24
`define VMEM_PPN_W    14

// Physical side
`define VMEM_OFS_W    8
`define VMEM_PMA_W    22

// Page address fields as carried on mapi
`define VMEM_VMA_W    32
`define VMEM_PAGE_MSB 23
`define VMEM_PAGE_LSB 8
`define VMEM_L1_LSB   13
`define VMEM_SEL_W    5

`endif
